// File: hdl/audio_pace_config.svh
//====================
// build-time sizes for the audio pacing subsystem
// include wherever a width or depth is needed
// FIFO depth must stay a power of two
//====================
`ifndef AUDIO_PACE_CONFIG_SVH
`define AUDIO_PACE_CONFIG_SVH

// numerator / denominator width of the pacers
`define AP_RATE_W 10

// divided enables per pacer, each one half the rate of the previous
`define AP_CEN_W 2

`define AP_FIFO_DEPTH 8   // sample buffer entries
`define AP_SAMPLE_W 16    // one sample word

`endif

// File: hdl/audio_pace_pkg.sv
//====================
// shared types for the audio pacing subsystem
// sample word union, channel mode, rate counter type
//====================
`include "audio_pace_config.svh"

package audio_pace_pkg;

    // numerator or denominator of a fractional rate
    typedef logic [`AP_RATE_W-1:0] rate_t;

    // how the sample word is read
    typedef enum logic {
        mode_mono   = 1'b0,
        mode_stereo = 1'b1
    } chan_mode_t;

    // two 8-bit channels, left in the upper byte
    typedef struct packed {
        logic [7:0] left;
        logic [7:0] right;
    } stereo_pair_t;

    // same 16 bits, two readings
    typedef union packed {
        logic [`AP_SAMPLE_W-1:0] mono;   // one unsigned sample
        stereo_pair_t            stereo; // left/right pair
    } sample_word_t;

endpackage

// File: hdl/audio_pace_top.sv
//====================
// audio pacing subsystem top
// source pacer drives the ramp producer, output pacer the serializer
// a FIFO over two Wishbone links sits between them
// src_cen / out_cen show the two rates
//====================
`include "audio_pace_config.svh"

module audio_pace_top (
    input  logic                       clk,
    input  logic                       rst,
    input  audio_pace_pkg::rate_t      src_n,  // producer rate n/m
    input  audio_pace_pkg::rate_t      src_m,
    input  audio_pace_pkg::rate_t      out_n,  // bit rate n/m
    input  audio_pace_pkg::rate_t      out_m,
    input  audio_pace_pkg::chan_mode_t mode,
    output logic                       sdata,
    output logic                       lrck,
    output logic                       frame_start,
    output logic                       frame_fill,
    output logic [7:0]                 overrun_cnt,
    output logic                       src_cen,
    output logic                       out_cen
);

    // only bit 0 leaves the pacers, divided ones stay here
    logic [`AP_CEN_W-1:0] src_cens;
    logic [`AP_CEN_W-1:0] out_cens;

    sample_bus_if wr_bus ();  // producer -> FIFO
    sample_bus_if rd_bus ();  // FIFO -> serializer

    frac_cen src_pace (
        .clk  (clk),
        .rst  (rst),
        .n    (src_n),
        .m    (src_m),
        .cen  (src_cens),
        .cenb ()
    );

    frac_cen out_pace (
        .clk  (clk),
        .rst  (rst),
        .n    (out_n),
        .m    (out_m),
        .cen  (out_cens),
        .cenb ()
    );

    sample_source source_i (
        .clk         (clk),
        .rst         (rst),
        .tick        (src_cens[0]),
        .mode        (mode),
        .bus         (wr_bus.master),
        .overrun_cnt (overrun_cnt)
    );

    sample_fifo fifo_i (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.slave),
        .rd  (rd_bus.slave)
    );

    sample_serializer serializer_i (
        .clk         (clk),
        .rst         (rst),
        .bit_tick    (out_cens[0]),
        .mode        (mode),
        .bus         (rd_bus.master),
        .sdata       (sdata),
        .lrck        (lrck),
        .frame_start (frame_start),
        .frame_fill  (frame_fill)
    );

    assign src_cen = src_cens[0];
    assign out_cen = out_cens[0];

endmodule

// File: hdl/frac_cen.sv
//====================
// fractional clock enable generator
// cen[0] fires n times every m clocks on average (n <= m)
// cen[k] fires on every other cen[k-1], cenb is the half-period version
// a counter that runs past m+n restarts from zero
//====================
`include "audio_pace_config.svh"

module frac_cen (
    input  logic                  clk,
    input  logic                  rst,
    input  audio_pace_pkg::rate_t n,    // numerator
    input  audio_pace_pkg::rate_t m,    // denominator
    output logic [`AP_CEN_W-1:0]  cen,
    output logic [`AP_CEN_W-1:0]  cenb  // shifted by half a period
);

    localparam int AW = `AP_RATE_W + 1; // one extra bit for the sum
    localparam int CW = `AP_CEN_W;

    logic [AW-1:0] step;
    logic [AW-1:0] lim;
    logic [AW-1:0] absmax;
    logic [AW-1:0] cencnt;
    logic [AW-1:0] next;
    logic [AW-1:0] next2;

    logic half;     // cenb already given this period
    logic over;
    logic halfway;

    // only bits feeding the divided enables
    logic [CW-2:0] edgecnt;
    logic [CW-2:0] edgecnt_b;
    logic [CW-2:0] toggle;
    logic [CW-2:0] toggle_b;

    assign step   = {1'b0, n};
    assign lim    = {1'b0, m};
    assign absmax = lim + step; // never reached in normal running

    assign next  = cencnt + step;
    assign next2 = next - lim;    // wrap value after a pulse

    assign over    = next >= lim;
    assign halfway = (next >= (lim >> 1)) && !half;

    // rising bits of the edge counters
    assign toggle   = (edgecnt + 1'b1) & ~edgecnt;
    assign toggle_b = (edgecnt_b + 1'b1) & ~edgecnt_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            cencnt    <= '0;
            half      <= 1'b0;
            edgecnt   <= '0;
            edgecnt_b <= '0;
            cen       <= '0;
            cenb      <= '0;
        end else begin
            cen  <= '0; // pulses only
            cenb <= '0;
            if (cencnt >= absmax) begin
                // run-away, e.g. m lowered under us
                cencnt <= '0;
                half   <= 1'b0;
            end else begin
                if (halfway) begin
                    half      <= 1'b1;
                    edgecnt_b <= edgecnt_b + 1'b1;
                    cenb      <= {toggle_b, 1'b1};
                end
                if (over) begin
                    cencnt  <= next2;
                    half    <= 1'b0;  // new period
                    edgecnt <= edgecnt + 1'b1;
                    cen     <= {toggle, 1'b1};
                end else begin
                    cencnt <= next;
                end
            end
        end
    end

endmodule

// File: hdl/sample_bus_if.sv
//====================
// Wishbone classic link carrying sample words
// master raises cyc+stb and holds we/dat_w until ack
// slave acks for a single cycle, read data valid with ack
//====================
interface sample_bus_if;
    import audio_pace_pkg::*;

    logic         cyc;   // bus cycle in progress
    logic         stb;   // strobe, same timing as cyc here
    logic         we;    // 1 = write
    sample_word_t dat_w; // master to slave
    sample_word_t dat_r; // slave to master
    logic         ack;   // one cycle

    modport master (
        output cyc, stb, we, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, dat_w,
        output dat_r, ack
    );

endinterface

// File: hdl/sample_fifo.sv
//====================
// sample buffer between the two rate domains
// write slave acks one cycle after stb unless full
// read slave acks one cycle after stb unless empty, data valid with ack
//====================
`include "audio_pace_config.svh"

module sample_fifo (
    input  logic        clk,
    input  logic        rst,
    sample_bus_if.slave wr,  // from the producer
    sample_bus_if.slave rd   // from the serializer
);
    import audio_pace_pkg::*;

    localparam int DEPTH = `AP_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    sample_word_t mem [DEPTH];

    logic [AW:0] wp;   // extra wrap bit
    logic [AW:0] rp;
    logic        full;
    logic        empty;
    logic        wr_go;
    logic        rd_go;
    logic        wr_ack;
    logic        rd_ack;
    sample_word_t rd_q;

    assign empty = (wp == rp);
    assign full  = (wp[AW] != rp[AW]) && (wp[AW-1:0] == rp[AW-1:0]);

    // request seen and not yet answered
    assign wr_go = wr.cyc && wr.stb && wr.we && !wr_ack && !full;
    assign rd_go = rd.cyc && rd.stb && !rd.we && !rd_ack && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wp     <= '0;
            rp     <= '0;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_go;   // single-cycle ack
            rd_ack <= rd_go;
            if (wr_go)
                wp <= wp + 1'b1;
            if (rd_go)
                rp <= rp + 1'b1;
        end
    end

    // storage and read register carry no reset
    always_ff @(posedge clk) begin
        if (wr_go)
            mem[wp[AW-1:0]] <= wr.dat_w;
        if (rd_go)
            rd_q <= mem[rp[AW-1:0]];  // lands with ack
    end

    assign wr.ack   = wr_ack;
    assign wr.dat_r = '0;     // write port returns nothing
    assign rd.ack   = rd_ack;
    assign rd.dat_r = rd_q;

endmodule

// File: hdl/sample_serializer.sv
//====================
// serial sample output, MSB first, one bit per bit_tick
// mono frames are 16 bits, stereo sends left (lrck low) then right
// next word is fetched from the FIFO while the current frame runs
// a frame with no word ready goes out as zeros with frame_fill low
//====================
`include "audio_pace_config.svh"

module sample_serializer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       bit_tick,    // output rate enable
    input  audio_pace_pkg::chan_mode_t mode,
    sample_bus_if.master               bus,
    output logic                       sdata,
    output logic                       lrck,        // high on right channel
    output logic                       frame_start, // with the first bit
    output logic                       frame_fill   // frame carries data
);
    import audio_pace_pkg::*;

    localparam int SW    = `AP_SAMPLE_W;
    localparam int CNT_W = $clog2(SW);

    logic [SW-1:0]    shreg;      // remaining bits of the frame
    logic [CNT_W-1:0] bit_cnt;    // bits still to send after current
    logic [CNT_W-1:0] frame_len;
    sample_word_t     nxt;        // prefetched word
    logic             have_word;
    logic             right_next; // stereo, next frame is the right byte
    logic             right_ok;   // right byte came with a real word
    logic [7:0]       right_byte;
    logic             fetch;      // read cycle on the bus
    logic             boundary;
    logic             consume;
    logic [SW-1:0]    first_word; // frame contents, left aligned
    logic             first_fill;

    assign frame_len = (mode == mode_mono) ? CNT_W'(SW - 1) : CNT_W'(SW / 2 - 1);
    assign boundary  = bit_tick && (bit_cnt == '0);
    assign consume   = boundary && have_word && (mode == mode_mono || !right_next);

    // decode the union for the frame about to start
    always_comb begin
        first_word = '0;
        first_fill = 1'b0;
        if (mode == mode_mono) begin
            first_word = have_word ? nxt.mono : '0;
            first_fill = have_word;
        end else if (!right_next) begin
            first_word = have_word ? {nxt.stereo.left, 8'h00} : '0;
            first_fill = have_word;
        end else begin
            first_word = right_ok ? {right_byte, 8'h00} : '0;
            first_fill = right_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch       <= 1'b0;
            have_word   <= 1'b0;
            bit_cnt     <= '0;   // first tick opens a frame
            right_next  <= 1'b0;
            right_ok    <= 1'b0;
            sdata       <= 1'b0;
            lrck        <= 1'b0;
            frame_start <= 1'b0;
            frame_fill  <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            // prefetch, cyc only while no word is held
            if (fetch) begin
                if (bus.ack) begin
                    fetch     <= 1'b0;
                    have_word <= 1'b1;
                end
            end else if (!have_word) begin
                fetch <= 1'b1;
            end
            if (consume)
                have_word <= 1'b0;
            if (boundary) begin
                sdata       <= first_word[SW-1];
                bit_cnt     <= frame_len;
                frame_start <= 1'b1;
                frame_fill  <= first_fill;
                lrck        <= (mode == mode_stereo) && right_next;
                right_next  <= (mode == mode_stereo) && !right_next;
                if (mode == mode_stereo && !right_next)
                    right_ok <= have_word; // right half follows its left
            end else if (bit_tick) begin
                sdata   <= shreg[SW-1];
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (fetch && bus.ack)
            nxt <= bus.dat_r;
        if (boundary) begin
            shreg <= first_word << 1;
            if (mode == mode_stereo && !right_next)
                right_byte <= nxt.stereo.right;
        end else if (bit_tick) begin
            shreg <= shreg << 1;
        end
    end

    assign bus.cyc   = fetch;
    assign bus.stb   = fetch;
    assign bus.we    = 1'b0;  // read-only master
    assign bus.dat_w = '0;

endmodule

// File: hdl/sample_source.sv
//====================
// ramp test tone producer
// writes one sample per tick into the FIFO over Wishbone
// ramp only advances on ack, late ticks count as overruns
//====================
`include "audio_pace_config.svh"

module sample_source (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       tick,        // source rate enable
    input  audio_pace_pkg::chan_mode_t mode,
    sample_bus_if.master               bus,
    output logic [7:0]                 overrun_cnt  // saturating
);
    import audio_pace_pkg::*;

    logic [`AP_SAMPLE_W-1:0] ramp;
    sample_word_t            word;   // next sample, built for the mode
    sample_word_t            dat_q;  // held during the write
    logic                    busy;   // write pending

    always_comb begin
        word = '0;
        if (mode == mode_mono) begin
            word.mono = ramp;
        end else begin
            word.stereo.left  = ramp[7:0];
            word.stereo.right = ~ramp[7:0]; // inverse of left
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            ramp        <= '0;
            overrun_cnt <= '0;
        end else begin
            if (busy) begin
                if (bus.ack) begin
                    busy <= 1'b0;       // drop cyc/stb next cycle
                    ramp <= ramp + 1'b1;
                end
            end else if (tick) begin
                busy <= 1'b1;
            end
            // tick lost while a write is still out
            if (tick && busy && overrun_cnt != 8'hff)
                overrun_cnt <= overrun_cnt + 1'b1;
        end
    end

    // payload, captured at the start of the write
    always_ff @(posedge clk) begin
        if (!busy && tick)
            dat_q <= word;
    end

    assign bus.cyc   = busy;
    assign bus.stb   = busy;
    assign bus.we    = busy;  // write-only master
    assign bus.dat_w = dat_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# exit status 0 only when the log shows a clean pass

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_audio_pace -f tb.f -o tb_audio_pace
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_audio_pace > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "simulation ended without a pass line"
    exit 1
fi
exit 0

// File: sim/tb_audio_pace.sv
//====================
// testbench for the audio pacing subsystem
// walks reset, pacer rate, mono and stereo streams, back-pressure
// a deserializer model rebuilds frames from sdata and tracks the ramp
// concurrent assertions do the checking, the first failure stops the run
//====================

module tb_audio_pace;
    import audio_pace_pkg::*;

    // phase lengths in clocks, summed for the timeout
    localparam int RST_CYC    = 5;
    localparam int RATE_CYC   = 3 * (RST_CYC + 8 * 71 + 2);   // m is at most 71
    localparam int MONO_FR    = 40;                          // filled frames wanted
    localparam int STEREO_FR  = 40;
    localparam int BP_FR      = 12;
    localparam int MONO_CYC   = RST_CYC + MONO_FR * 64 + 200;
    localparam int STEREO_CYC = RST_CYC + STEREO_FR * 40 + 200;
    localparam int BP_CYC     = RST_CYC + BP_FR * 256 + 512;  // 256 clocks per frame
    localparam int LIMIT      = (RATE_CYC + MONO_CYC + STEREO_CYC + BP_CYC) * 11 / 10;

    logic       clk;
    logic       rst;
    rate_t      src_n;
    rate_t      src_m;
    rate_t      out_n;
    rate_t      out_m;
    chan_mode_t mode;
    logic       sdata;
    logic       lrck;
    logic       frame_start;
    logic       frame_fill;
    logic [7:0] overrun_cnt;
    logic       src_cen;
    logic       out_cen;

    // phase flags, driven with the inputs
    logic        rst_chk  = 1'b0;  // outputs must read 0
    logic        rate_chk = 1'b0;  // one cycle, count ready
    logic        bp_chk   = 1'b0;
    int          rate_cnt = 0;
    int          rate_exp = 0;
    logic [31:0] lfsr     = 32'h5030;
    int          cycle_cnt = 0;

    // deserializer model state, updated on the falling edge
    logic        is_stereo;
    logic        tick_q      = 1'b0;  // out_cen seen last cycle
    logic        in_frame    = 1'b0;
    logic        frame_done  = 1'b0;  // frm_* hold a whole frame
    logic        cut_frame   = 1'b0;
    logic        fill_steady = 1'b1;
    logic [15:0] frm_bits    = '0;
    logic        frm_fill    = 1'b0;
    logic        frm_lr      = 1'b0;
    int          bit_cnt     = 0;
    logic [15:0] exp_word    = '0;    // ramp model
    logic        exp_lr      = 1'b0;
    logic [7:0]  exp_right   = '0;    // right byte of the current pair
    logic        last_fill   = 1'b0;
    int          filled_cnt  = 0;    // samples seen on the output

    assign is_stereo = (mode == mode_stereo);

    audio_pace_top audio_pace_top_i (
        .clk         (clk),
        .rst         (rst),
        .src_n       (src_n),
        .src_m       (src_m),
        .out_n       (out_n),
        .out_m       (out_m),
        .mode        (mode),
        .sdata       (sdata),
        .lrck        (lrck),
        .frame_start (frame_start),
        .frame_fill  (frame_fill),
        .overrun_cnt (overrun_cnt),
        .src_cen     (src_cen),
        .out_cen     (out_cen)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("Error at %0t: %s expected %0h actual %0h", $time, name, exp, got);
        fail_run();
    endtask

    task automatic report_issue(input string what);
        $display("Failure at %0t: %s", $time, what);
        fail_run();
    endtask

    // one Galois step, returns the bit shifted out
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'hA300_0000;
        return b;
    endfunction

    function automatic int take_bits(input int k);
        int v;
        v = 0;
        for (int i = 0; i < k; i++)
            v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    task automatic step();
        @(posedge clk);
        #5;  // inputs move just after the edge
    endtask

    // 4 reset edges, returns just after the first edge out of reset
    task automatic do_reset();
        rst = 1'b1;
        step();
        rst_chk = 1'b1;
        repeat (3) step();
        rst = 1'b0;
        step();
        rst_chk = 1'b0;
    endtask

    task automatic set_rates(input int sn, input int sm, input int on, input int om);
        src_n = rate_t'(sn);
        src_m = rate_t'(sm);
        out_n = rate_t'(on);
        out_m = rate_t'(om);
    endtask

    // deserializer model
    always @(negedge clk) begin
        if (rst) begin
            tick_q      = 1'b0;
            in_frame    = 1'b0;
            frame_done  = 1'b0;
            cut_frame   = 1'b0;
            fill_steady = 1'b1;
            bit_cnt     = 0;
            exp_word    = '0;
            exp_lr      = 1'b0;
            exp_right   = '0;
            last_fill   = 1'b0;
            filled_cnt  = 0;
        end else begin
            if (frame_done) begin  // frame was checked at the last rising edge
                frame_done = 1'b0;
                if (is_stereo) begin
                    exp_lr = !exp_lr;
                    if (!frm_lr) begin
                        exp_right = ~exp_word[7:0];  // inverse of the model left byte
                        last_fill = frm_fill;
                    end
                end
                if (frm_fill && !(is_stereo && frm_lr)) begin
                    exp_word   = exp_word + 16'd1;
                    filled_cnt = filled_cnt + 1;
                end
            end
            if (tick_q) begin  // new bit on sdata this cycle
                if (frame_start) begin
                    if (in_frame)
                        cut_frame = 1'b1;
                    in_frame    = 1'b1;
                    frm_bits    = {15'd0, sdata};
                    frm_fill    = frame_fill;
                    frm_lr      = lrck;
                    fill_steady = 1'b1;
                    bit_cnt     = 1;
                end else if (in_frame) begin
                    frm_bits = {frm_bits[14:0], sdata};
                    if (frame_fill != frm_fill)
                        fill_steady = 1'b0;
                    bit_cnt = bit_cnt + 1;
                end
                if (in_frame && bit_cnt == (is_stereo ? 8 : 16)) begin
                    frame_done = 1'b1;
                    in_frame   = 1'b0;
                end
            end
            tick_q = out_cen;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("Timeout: run still going after %0d cycles", LIMIT);
            fail_run();
        end
    end

    // reset values
    a_rst_src: assert property (@(posedge clk) rst_chk |-> !src_cen)
        else report_value("src_cen", 0, $sampled(src_cen));
    a_rst_out: assert property (@(posedge clk) rst_chk |-> !out_cen)
        else report_value("out_cen", 0, $sampled(out_cen));
    a_rst_fs: assert property (@(posedge clk) rst_chk |-> !frame_start)
        else report_value("frame_start", 0, $sampled(frame_start));
    a_rst_ff: assert property (@(posedge clk) rst_chk |-> !frame_fill)
        else report_value("frame_fill", 0, $sampled(frame_fill));
    a_rst_ovr: assert property (@(posedge clk) rst_chk |-> overrun_cnt == 8'd0)
        else report_value("overrun_cnt", 0, $sampled(overrun_cnt));

    a_rate: assert property (@(posedge clk) rate_chk |-> rate_cnt == rate_exp)
        else report_value("src_cen pulse count", rate_exp, rate_cnt);

    // frame contents against the ramp model
    a_mono: assert property (@(posedge clk)
        frame_done && !is_stereo && frm_fill |-> frm_bits == exp_word)
        else report_value("sdata mono frame", exp_word, frm_bits);
    a_zero: assert property (@(posedge clk) frame_done && !frm_fill |-> frm_bits == 16'd0)
        else report_value("sdata unfilled frame", 0, frm_bits);
    a_lr: assert property (@(posedge clk) frame_done && is_stereo |-> frm_lr == exp_lr)
        else report_value("lrck", exp_lr, frm_lr);
    a_left: assert property (@(posedge clk)
        frame_done && is_stereo && frm_fill && !frm_lr |-> frm_bits[7:0] == exp_word[7:0])
        else report_value("sdata left byte", exp_word[7:0], frm_bits[7:0]);
    a_right: assert property (@(posedge clk)
        frame_done && is_stereo && frm_fill && frm_lr |-> frm_bits[7:0] == exp_right)
        else report_value("sdata right byte", exp_right, frm_bits[7:0]);
    a_rfill: assert property (@(posedge clk)
        frame_done && is_stereo && frm_lr |-> frm_fill == last_fill)
        else report_value("frame_fill right frame", last_fill, frm_fill);
    a_steady: assert property (@(posedge clk) frame_done |-> fill_steady)
        else report_issue("frame_fill changed in the middle of a frame");
    a_cut: assert property (@(posedge clk) !cut_frame)
        else report_issue("frame_start came before the previous frame was complete");

    a_overrun: assert property (@(posedge clk) bp_chk |-> overrun_cnt != 8'd0)
        else report_value("overrun_cnt", 1, $sampled(overrun_cnt));

    initial begin
        int m_val;
        int n_val;
        int cnt;
        rst  = 1'b1;
        mode = mode_mono;
        set_rates(1, 2, 1, 2);

        // fractional rate, restarted from reset for each pair
        for (int i = 0; i < 3; i++) begin
            m_val = 8 + take_bits(6);
            n_val = 1 + take_bits(7) % m_val;   // keeps n <= m
            set_rates(n_val, m_val, 1, 2);
            do_reset();
            cnt = 0;
            repeat (8 * m_val) begin
                if (src_cen)
                    cnt++;
                step();
            end
            rate_cnt = cnt;
            rate_exp = 8 * n_val;
            rate_chk = 1'b1;
            step();
            rate_chk = 1'b0;
        end

        // mono, output twice as fast as the source
        mode = mode_mono;
        set_rates(1, 64, 1, 2);
        do_reset();
        while (filled_cnt < MONO_FR)
            step();

        // stereo pairs, left then right
        mode = mode_stereo;
        set_rates(1, 40, 3, 5);
        do_reset();
        while (filled_cnt < STEREO_FR)
            step();

        // slow output, FIFO fills and the source overruns
        mode = mode_mono;
        set_rates(1, 4, 1, 16);
        do_reset();
        while (filled_cnt < BP_FR)
            step();
        bp_chk = 1'b1;
        step();
        bp_chk = 1'b0;
        step();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/audio_pace_pkg.sv
hdl/sample_bus_if.sv
hdl/frac_cen.sv
hdl/sample_source.sv
hdl/sample_fifo.sv
hdl/sample_serializer.sv
hdl/audio_pace_top.sv
sim/tb_audio_pace.sv
